//--- source/poly_cmd_pkg.sv
package poly_cmd_pkg;

   // Command word holds opcode, polynomial A and count, from the top bit down
   localparam int instr_width   = 8;
   localparam int poly_id_width = 3;
   localparam int count_width   = 5;

   localparam logic [instr_width-1:0] opcode_stp = 8'd0;  // Load the coefficients of A
   localparam logic [instr_width-1:0] opcode_evp = 8'd1;  // Evaluate A at one x
   localparam logic [instr_width-1:0] opcode_evb = 8'd2;  // Evaluate A at a block of x values
   localparam logic [instr_width-1:0] opcode_rst = 8'd3;  // Mark every polynomial empty

   // Firing modes given by the scheduler
   localparam logic [1:0] mode_setup = 2'd0;
   localparam logic [1:0] mode_instr = 2'd1;

   // Status word repeats the opcode and A in bits 15 to 5 of the command layout
   localparam int status_error_bit = 0;

endpackage

//--- source/poly_mem_pkg.sv
package poly_mem_pkg;

   localparam int word_width       = 16;  // Every FIFO token
   localparam int result_width     = 32;  // Result and status words
   localparam int num_polys        = 8;
   localparam int max_degree       = 10;
   localparam int degree_width     = 4;
   localparam int slot_size        = 11;  // Coefficients reserved per polynomial
   localparam int coeff_depth      = 88;
   localparam int coeff_addr_width = 7;

endpackage

//--- source/command_fetch.sv
module command_fetch
(
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   start_fetch,
   input  logic [poly_mem_pkg::word_width-1:0]    command_in,
   output logic                                   rd_command,
   output logic                                   done_fetch,
   output logic [poly_cmd_pkg::instr_width-1:0]   instr,
   output logic [poly_cmd_pkg::poly_id_width-1:0] arg_poly,
   output logic [poly_cmd_pkg::count_width-1:0]   arg_count
);

   logic capture;  // The command token is on command_in in this cycle

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         rd_command <= 1'b0;
         capture    <= 1'b0;
         done_fetch <= 1'b0;
         instr      <= '0;
         arg_poly   <= '0;
         arg_count  <= '0;
      end
      else
      begin
         rd_command <= start_fetch;
         capture    <= rd_command;  // FIFO answers one cycle after the strobe
         done_fetch <= capture;
         if (capture)
         begin
            // Fields stay put until the next setup firing
            instr     <= command_in[poly_mem_pkg::word_width-1 -: poly_cmd_pkg::instr_width];
            arg_poly  <= command_in[poly_cmd_pkg::count_width +: poly_cmd_pkg::poly_id_width];
            arg_count <= command_in[poly_cmd_pkg::count_width-1:0];
         end
      end
   end

endmodule

//--- source/coeff_store.sv
module coeff_store
(
   input  logic                                        clk,
   input  logic                                        rst,
   input  logic                                        clear_all,
   input  logic                                        wr_coeff,
   input  logic [poly_mem_pkg::coeff_addr_width-1:0]   wr_coeff_addr,
   input  logic [poly_mem_pkg::word_width-1:0]         wr_coeff_data,
   input  logic                                        wr_degree,
   input  logic [poly_cmd_pkg::poly_id_width-1:0]      wr_poly,
   input  logic [poly_mem_pkg::degree_width-1:0]       wr_degree_data,
   input  logic [poly_mem_pkg::coeff_addr_width-1:0]   rd_coeff_addr,
   input  logic [poly_cmd_pkg::poly_id_width-1:0]      rd_poly,
   output logic [poly_mem_pkg::word_width-1:0]         rd_coeff_data,
   output logic [poly_mem_pkg::degree_width-1:0]       rd_degree,
   output logic                                        rd_valid
);

   logic [poly_mem_pkg::word_width-1:0]   coeff_mem [poly_mem_pkg::coeff_depth];
   logic [poly_mem_pkg::degree_width-1:0] degree_tab [poly_mem_pkg::num_polys];
   logic [poly_mem_pkg::num_polys-1:0]    valid_tab;

   always_ff @(posedge clk)
   begin
      if (wr_coeff)
         coeff_mem[wr_coeff_addr] <= wr_coeff_data;
      rd_coeff_data <= coeff_mem[rd_coeff_addr];  // Data one cycle after the address
   end

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         for (int k = 0; k < poly_mem_pkg::num_polys; k++)
            degree_tab[k] <= '0;
         valid_tab <= '0;
      end
      else if (clear_all)
      begin
         for (int k = 0; k < poly_mem_pkg::num_polys; k++)
            degree_tab[k] <= '0;
         valid_tab <= '0;
      end
      else if (wr_degree)
      begin
         degree_tab[wr_poly] <= wr_degree_data;
         valid_tab[wr_poly]  <= 1'b1;  // A polynomial is valid once its degree is known
      end
   end

   assign rd_degree = degree_tab[rd_poly];
   assign rd_valid  = valid_tab[rd_poly];

endmodule

//--- source/coeff_loader.sv
module coeff_loader
(
   input  logic                                        clk,
   input  logic                                        rst,
   input  logic                                        start_load,
   input  logic [poly_cmd_pkg::poly_id_width-1:0]      arg_poly,
   input  logic [poly_cmd_pkg::count_width-1:0]        arg_count,
   input  logic [poly_mem_pkg::word_width-1:0]         data_in,
   output logic                                        rd_data_load,
   output logic                                        wr_coeff,
   output logic [poly_mem_pkg::coeff_addr_width-1:0]   wr_coeff_addr,
   output logic [poly_mem_pkg::word_width-1:0]         wr_coeff_data,
   output logic                                        wr_degree,
   output logic [poly_cmd_pkg::poly_id_width-1:0]      wr_poly,
   output logic [poly_mem_pkg::degree_width-1:0]       wr_degree_data,
   output logic                                        done_load,
   output logic                                        load_error
);

   localparam logic [1:0] L_IDLE    = 2'd0;
   localparam logic [1:0] L_READ    = 2'd1;
   localparam logic [1:0] L_CAPTURE = 2'd2;

   logic [1:0]                           state;
   logic [poly_cmd_pkg::count_width-1:0] idx;  // Coefficient position of the current token

   // A degree above the limit still drains its tokens but stores nothing
   assign load_error     = arg_count > poly_mem_pkg::max_degree;
   assign rd_data_load   = state == L_READ;
   assign wr_coeff       = state == L_CAPTURE && !load_error;
   assign wr_coeff_addr  =
      poly_mem_pkg::coeff_addr_width'(arg_poly * poly_mem_pkg::slot_size + idx);
   assign wr_coeff_data  = data_in;
   assign wr_degree      = done_load && !load_error;  // Degree lands after the last coefficient
   assign wr_poly        = arg_poly;
   assign wr_degree_data = arg_count[poly_mem_pkg::degree_width-1:0];

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state     <= L_IDLE;
         idx       <= '0;
         done_load <= 1'b0;
      end
      else
      begin
         done_load <= 1'b0;
         case (state)
            L_IDLE:
            begin
               idx <= '0;
               if (start_load)
                  state <= L_READ;
            end
            L_READ:
               state <= L_CAPTURE;
            L_CAPTURE:
            begin
               idx <= idx + 1'b1;
               if (idx == arg_count)
               begin
                  done_load <= 1'b1;
                  state     <= L_IDLE;
               end
               else
                  state <= L_READ;
            end
            default:
               state <= L_IDLE;
         endcase
      end
   end

endmodule

//--- source/poly_evaluator.sv
module poly_evaluator
(
   input  logic                                        clk,
   input  logic                                        rst,
   input  logic                                        start_eval,
   input  logic                                        block,
   input  logic [poly_cmd_pkg::poly_id_width-1:0]      arg_poly,
   input  logic [poly_cmd_pkg::count_width-1:0]        arg_count,
   input  logic [poly_mem_pkg::word_width-1:0]         data_in,
   input  logic [poly_mem_pkg::word_width-1:0]         rd_coeff_data,
   input  logic [poly_mem_pkg::degree_width-1:0]       rd_degree,
   input  logic                                        rd_valid,
   output logic                                        rd_data_eval,
   output logic [poly_mem_pkg::coeff_addr_width-1:0]   rd_coeff_addr,
   output logic [poly_cmd_pkg::poly_id_width-1:0]      rd_poly,
   output logic [poly_mem_pkg::result_width-1:0]       result,
   output logic                                        eval_error,
   output logic                                        result_ready,
   output logic                                        done_eval
);

   localparam logic [2:0] E_IDLE    = 3'd0;
   localparam logic [2:0] E_READ    = 3'd1;
   localparam logic [2:0] E_CAPTURE = 3'd2;
   localparam logic [2:0] E_MAC     = 3'd3;
   localparam logic [2:0] E_RESULT  = 3'd4;

   logic [2:0]                             state;
   logic [poly_mem_pkg::degree_width-1:0]  idx;      // Coefficient index on the read address
   logic                                   at_zero;  // rd_coeff_data holds coefficient 0
   logic [poly_cmd_pkg::count_width-1:0]   n;        // Tokens finished in this firing
   logic [poly_mem_pkg::word_width-1:0]    x;
   logic [poly_mem_pkg::result_width-1:0]  acc;
   logic                                   last;

   assign last          = !block || n == arg_count;  // EVP is a block of one
   assign rd_poly       = arg_poly;
   assign rd_coeff_addr =
      poly_mem_pkg::coeff_addr_width'(arg_poly * poly_mem_pkg::slot_size + idx);
   assign rd_data_eval  = state == E_READ;
   assign result_ready  = state == E_RESULT;
   assign done_eval     = result_ready && last;
   assign result        = acc;

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state      <= E_IDLE;
         idx        <= '0;
         at_zero    <= 1'b0;
         n          <= '0;
         eval_error <= 1'b0;
      end
      else
      begin
         at_zero <= idx == '0;  // Store read latency delays the index by one cycle
         if (state != E_IDLE && state != E_RESULT && idx != '0)
            idx <= idx - 1'b1;
         case (state)
            E_IDLE:
               if (start_eval)
               begin
                  idx   <= rd_degree;  // Highest coefficient is read first
                  n     <= '0;
                  state <= E_READ;
               end
            E_READ:
               state <= E_CAPTURE;
            E_CAPTURE:
            begin
               eval_error <= !rd_valid;
               state      <= (at_zero || !rd_valid) ? E_RESULT : E_MAC;
            end
            E_MAC:
               if (at_zero)
                  state <= E_RESULT;
            E_RESULT:
               if (last)
                  state <= E_IDLE;
               else
               begin
                  idx   <= rd_degree;
                  n     <= n + 1'b1;
                  state <= E_READ;
               end
            default:
               state <= E_IDLE;
         endcase
      end
   end

   // Horner step, everything modulo 2^32
   always_ff @(posedge clk)
   begin
      if (state == E_CAPTURE)
      begin
         x   <= data_in;
         acc <= rd_valid ? poly_mem_pkg::result_width'(rd_coeff_data) : '0;
      end
      else if (state == E_MAC)
         acc <= acc * poly_mem_pkg::result_width'(x) + poly_mem_pkg::result_width'(rd_coeff_data);
   end

endmodule

//--- source/poly_firing_fsm.sv
module poly_firing_fsm
(
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   start,
   input  logic [1:0]                             mode,
   input  logic [poly_cmd_pkg::instr_width-1:0]   instr,
   input  logic [poly_cmd_pkg::poly_id_width-1:0] arg_poly,
   input  logic                                   done_fetch,
   input  logic                                   done_load,
   input  logic                                   load_error,
   input  logic                                   rd_data_load,
   input  logic                                   rd_data_eval,
   input  logic [poly_mem_pkg::result_width-1:0]  result_eval,
   input  logic                                   eval_error,
   input  logic                                   result_ready,
   input  logic                                   done_eval,
   output logic                                   start_fetch,
   output logic                                   start_load,
   output logic                                   start_eval,
   output logic                                   eval_block,
   output logic                                   clear_all,
   output logic                                   rd_data,
   output logic                                   wr_output,
   output logic [poly_mem_pkg::result_width-1:0]  result,
   output logic [poly_mem_pkg::result_width-1:0]  status,
   output logic                                   done
);

   localparam logic [3:0] S_IDLE        = 4'd0;
   localparam logic [3:0] S_FETCH_START = 4'd1;
   localparam logic [3:0] S_FETCH_WAIT  = 4'd2;
   localparam logic [3:0] S_FINISH      = 4'd3;
   localparam logic [3:0] S_LOAD_START  = 4'd4;
   localparam logic [3:0] S_LOAD_WAIT   = 4'd5;
   localparam logic [3:0] S_EVAL_START  = 4'd6;
   localparam logic [3:0] S_EVAL_WAIT   = 4'd7;
   localparam logic [3:0] S_OUTPUT      = 4'd8;
   localparam logic [3:0] S_CLEAR       = 4'd9;
   localparam logic [3:0] S_SKIP        = 4'd10;

   logic [3:0] state;
   logic       final_out;  // The pending output also ends the firing

   function automatic logic [poly_mem_pkg::result_width-1:0] make_status(input logic err);
      logic [poly_mem_pkg::result_width-1:0] s;
      s = '0;
      s[poly_mem_pkg::word_width-1 -: poly_cmd_pkg::instr_width]     = instr;
      s[poly_cmd_pkg::count_width +: poly_cmd_pkg::poly_id_width]    = arg_poly;
      s[poly_cmd_pkg::status_error_bit]                              = err;
      return s;
   endfunction

   assign start_fetch = state == S_FETCH_START;
   assign start_load  = state == S_LOAD_START;
   assign start_eval  = state == S_EVAL_START;
   assign clear_all   = state == S_CLEAR;
   assign eval_block  = instr == poly_cmd_pkg::opcode_evb;
   assign rd_data     = rd_data_load | rd_data_eval;  // Only one child reads at a time
   assign wr_output   = state == S_OUTPUT;
   assign done        = state == S_FINISH || (state == S_OUTPUT && final_out);

   always_ff @(posedge clk or negedge rst)
   begin
      if (!rst)
      begin
         state     <= S_IDLE;
         final_out <= 1'b0;
      end
      else
      begin
         case (state)
            S_IDLE:
               if (start)
               begin
                  if (mode == poly_cmd_pkg::mode_setup)
                     state <= S_FETCH_START;
                  else if (mode != poly_cmd_pkg::mode_instr)
                     state <= S_SKIP;
                  else
                     case (instr)
                        poly_cmd_pkg::opcode_stp:
                           state <= S_LOAD_START;
                        poly_cmd_pkg::opcode_evp,
                        poly_cmd_pkg::opcode_evb:
                           state <= S_EVAL_START;
                        poly_cmd_pkg::opcode_rst:
                           state <= S_CLEAR;
                        default:
                           state <= S_SKIP;  // Unknown opcode just finishes
                     endcase
               end
            S_FETCH_START:
               state <= S_FETCH_WAIT;
            S_FETCH_WAIT:
               if (done_fetch)
                  state <= S_FINISH;
            S_LOAD_START:
               state <= S_LOAD_WAIT;
            S_LOAD_WAIT:
               if (done_load)
               begin
                  final_out <= 1'b1;
                  state     <= S_OUTPUT;
               end
            S_EVAL_START:
               state <= S_EVAL_WAIT;
            S_EVAL_WAIT:
               if (result_ready)
               begin
                  final_out <= done_eval;
                  state     <= S_OUTPUT;
               end
            S_OUTPUT:
               state <= final_out ? S_IDLE : S_EVAL_WAIT;
            S_CLEAR,
            S_SKIP:
               state <= S_FINISH;
            default:
               state <= S_IDLE;  // S_FINISH and unused codes
         endcase
      end
   end

   // Output words are taken one cycle before wr_output
   always_ff @(posedge clk)
   begin
      if (done_load)
      begin
         result <= '0;
         status <= make_status(load_error);
      end
      else if (result_ready)
      begin
         result <= result_eval;
         status <= make_status(eval_error);
      end
   end

endmodule

//--- source/poly_actor.sv
module poly_actor
(
   input  logic                                   clk,
   input  logic                                   rst,
   input  logic                                   start,
   input  logic [1:0]                             mode,
   input  logic [poly_mem_pkg::word_width-1:0]    command_in,
   input  logic [poly_mem_pkg::word_width-1:0]    data_in,
   output logic                                   rd_command,
   output logic                                   rd_data,
   output logic [poly_cmd_pkg::instr_width-1:0]   instr,
   output logic                                   wr_output,
   output logic [poly_mem_pkg::result_width-1:0]  result,
   output logic [poly_mem_pkg::result_width-1:0]  status,
   output logic                                   done
);

   // Parent to child strobes and child answers
   logic start_fetch;
   logic start_load;
   logic start_eval;
   logic eval_block;
   logic clear_all;
   logic done_fetch;
   logic done_load;
   logic load_error;
   logic done_eval;
   logic eval_error;
   logic result_ready;
   logic rd_data_load;
   logic rd_data_eval;
   logic [poly_cmd_pkg::poly_id_width-1:0]    arg_poly;
   logic [poly_cmd_pkg::count_width-1:0]      arg_count;
   logic [poly_mem_pkg::result_width-1:0]     result_eval;

   // Coefficient store ports
   logic                                      wr_coeff;
   logic [poly_mem_pkg::coeff_addr_width-1:0] wr_coeff_addr;
   logic [poly_mem_pkg::word_width-1:0]       wr_coeff_data;
   logic                                      wr_degree;
   logic [poly_cmd_pkg::poly_id_width-1:0]    wr_poly;
   logic [poly_mem_pkg::degree_width-1:0]     wr_degree_data;
   logic [poly_mem_pkg::coeff_addr_width-1:0] rd_coeff_addr;
   logic [poly_cmd_pkg::poly_id_width-1:0]    rd_poly;
   logic [poly_mem_pkg::word_width-1:0]       rd_coeff_data;
   logic [poly_mem_pkg::degree_width-1:0]     rd_degree;
   logic                                      rd_valid;

   command_fetch u_fetch (.*);

   coeff_store u_store (.*);

   coeff_loader u_loader (.*);

   poly_evaluator u_eval
   (
      .*,
      .block  (eval_block),
      .result (result_eval)
   );

   poly_firing_fsm u_fsm (.*);

endmodule

//--- verification/tb_poly_actor.sv
module tb_poly_actor;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int num_commands   = 150;                   // Each command is two firings
   localparam int timeout_cycles = 2 * num_commands * 400;

   logic        clk;
   logic        rst;
   logic        start;
   logic [1:0]  mode;
   logic [15:0] command_in;
   logic [15:0] data_in;
   logic        rd_command;
   logic        rd_data;
   logic [7:0]  instr;
   logic        wr_output;
   logic [31:0] result;
   logic [31:0] status;
   logic        done;

   // FIFO contents and the tokens they answer with in the next cycle
   logic [15:0] cmd_q [$];
   logic [15:0] data_q [$];
   logic [15:0] command_next = '0;
   logic [15:0] data_next = '0;

   logic [31:0] expected_result_q [$];
   logic [31:0] expected_status_q [$];
   logic        done_with_output = 1'b0;  // The coming done ends a firing that writes outputs

   // Reference copy of the coefficient store
   logic [15:0] model_coeff [8][11];
   int          model_degree [8];
   logic        model_valid [8];

   integer seed;
   int     cycles = 0;

   poly_actor u_poly_actor
   (
      .clk        (clk),
      .rst        (rst),
      .start      (start),
      .mode       (mode),
      .command_in (command_in),
      .data_in    (data_in),
      .rd_command (rd_command),
      .rd_data    (rd_data),
      .instr      (instr),
      .wr_output  (wr_output),
      .result     (result),
      .status     (status),
      .done       (done)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic abort_run();
      $display("Simulation finished: FAIL");
      $fatal(1);
   endtask

   task automatic check_value(input string what, input logic [31:0] got,
                              input logic [31:0] expected);
      if (got !== expected)
      begin
         $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, got, expected);
         abort_run();
      end
   endtask

   function automatic int unsigned rand_below(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic logic [31:0] expected_status(input logic [7:0] op, input logic [2:0] a,
                                                   input logic err);
      return {16'h0000, op, a, 4'h0, err};
   endfunction

   // Horner's rule from the highest coefficient down, modulo 2^32
   function automatic logic [31:0] horner_value(input logic [2:0] a, input logic [15:0] x);
      logic [31:0] acc;
      acc = {16'h0000, model_coeff[a][model_degree[a]]};
      for (int i = model_degree[a] - 1; i >= 0; i--)
         acc = acc * {16'h0000, x} + {16'h0000, model_coeff[a][i]};
      return acc;
   endfunction

   // FIFO answers a strobe seen in the previous cycle
   always @(posedge clk)
   begin
      #1;
      command_in = command_next;
      data_in    = data_next;
   end

   // Outputs are sampled mid cycle where they are stable
   always @(negedge clk)
   begin
      cycles++;
      if (cycles > timeout_cycles)
      begin
         $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
         abort_run();
      end
      if (rd_command)
      begin
         if (cmd_q.size() == 0)
         begin
            $display("The actor read the command FIFO while it was empty");
            abort_run();
         end
         command_next = cmd_q.pop_front();
      end
      if (rd_data)
      begin
         if (data_q.size() == 0)
         begin
            $display("The actor read the data FIFO while it was empty");
            abort_run();
         end
         data_next = data_q.pop_front();
      end
      if (wr_output)
      begin
         if (expected_result_q.size() == 0)
         begin
            $display("The actor wrote an output that was not expected");
            abort_run();
         end
         check_value("result", result, expected_result_q.pop_front());
         check_value("status", status, expected_status_q.pop_front());
      end
      if (done && expected_result_q.size() != 0)
      begin
         $display("Done came before the last output of the firing");
         abort_run();
      end
      if (done && done_with_output && !wr_output)
      begin
         $display("Done came without the last output of the firing");
         abort_run();
      end
   end

   // One firing, from the start pulse to the done pulse
   task automatic fire(input logic [1:0] m);
      @(posedge clk);
      #1;
      mode  = m;
      start = 1'b1;
      @(posedge clk);
      #1;
      start = 1'b0;
      @(negedge clk);
      while (!done)
         @(negedge clk);
      @(posedge clk);
   endtask

   task automatic expect_output(input logic [31:0] res, input logic [31:0] stat);
      expected_result_q.push_back(res);
      expected_status_q.push_back(stat);
   endtask

   task automatic run_command();
      int unsigned pick;
      logic [7:0]  opcode;
      logic [2:0]  a;
      logic [4:0]  count;
      logic [15:0] token;
      int          n_tokens;
      pick  = rand_below(16);
      a     = 3'(rand_below(8));
      count = 5'(rand_below(32));
      if (pick < 6)
      begin
         opcode = poly_cmd_pkg::opcode_stp;
         // Mostly legal degrees, now and then one above the limit
         count  = (rand_below(8) == 0) ? 5'(11 + rand_below(21)) : 5'(rand_below(11));
      end
      else if (pick < 10)
         opcode = poly_cmd_pkg::opcode_evp;
      else if (pick < 13)
      begin
         opcode = poly_cmd_pkg::opcode_evb;
         count  = 5'(rand_below(8));
      end
      else if (pick < 14)
         opcode = poly_cmd_pkg::opcode_rst;
      else
         opcode = 8'(4 + rand_below(252));  // Unknown opcode

      cmd_q.push_back({opcode, a, count});
      fire(poly_cmd_pkg::mode_setup);
      check_value("instr after setup", 32'(instr), 32'(opcode));

      if (opcode == poly_cmd_pkg::opcode_stp)
      begin
         for (int i = 0; i <= int'(count); i++)
         begin
            token = 16'(rand_below(65536));
            data_q.push_back(token);
            if (count <= 5'd10)
               model_coeff[a][i] = token;
         end
         if (count <= 5'd10)
         begin
            model_degree[a] = int'(count);
            model_valid[a]  = 1'b1;
         end
         expect_output(32'd0, expected_status(opcode, a, count > 5'd10));
      end
      else if (opcode == poly_cmd_pkg::opcode_evp || opcode == poly_cmd_pkg::opcode_evb)
      begin
         n_tokens = (opcode == poly_cmd_pkg::opcode_evb) ? int'(count) + 1 : 1;
         for (int i = 0; i < n_tokens; i++)
         begin
            token = 16'(rand_below(65536));
            data_q.push_back(token);
            expect_output(model_valid[a] ? horner_value(a, token) : 32'd0,
                          expected_status(opcode, a, !model_valid[a]));
         end
      end
      else if (opcode == poly_cmd_pkg::opcode_rst)
      begin
         for (int k = 0; k < 8; k++)
            model_valid[k] = 1'b0;
      end

      done_with_output = expected_result_q.size() != 0;
      fire(poly_cmd_pkg::mode_instr);
      done_with_output = 1'b0;
      if (data_q.size() != 0)
      begin
         $display("The firing left %0d data tokens unread", data_q.size());
         abort_run();
      end
   endtask

   initial
   begin
      rst        = 1'b0;
      start      = 1'b0;
      mode       = poly_cmd_pkg::mode_setup;
      command_in = '0;
      data_in    = '0;
      seed       = 32'hf050_8e67;
      for (int k = 0; k < 8; k++)
      begin
         model_valid[k]  = 1'b0;
         model_degree[k] = 0;
      end
      repeat (16) @(posedge clk);
      #1;
      rst = 1'b1;

      @(negedge clk);
      check_value("done after reset", 32'(done), 32'd0);
      check_value("wr_output after reset", 32'(wr_output), 32'd0);
      check_value("rd_command after reset", 32'(rd_command), 32'd0);
      check_value("rd_data after reset", 32'(rd_data), 32'd0);
      check_value("instr after reset", 32'(instr), 32'd0);

      for (int n = 0; n < num_commands; n++)
         run_command();

      @(posedge clk);
      if (expected_result_q.size() != 0)
      begin
         $display("%0d expected outputs never appeared", expected_result_q.size());
         abort_run();
      end
      else
      begin
         $display("Simulation finished: PASS");
         $finish;
      end
   end

endmodule

//--- verilog.f
source/poly_cmd_pkg.sv
source/poly_mem_pkg.sv
source/command_fetch.sv
source/coeff_store.sv
source/coeff_loader.sv
source/poly_evaluator.sv
source/poly_firing_fsm.sv
source/poly_actor.sv
verification/tb_poly_actor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the polynomial actor testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "Cannot change to the project root"
   exit 1
fi

verilator --binary --timing -Wno-fatal --top-module tb_poly_actor \
   -f verilog.f -o sim_poly_actor
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/sim_poly_actor)
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if grep -q "Simulation finished: PASS" <<< "$output"; then
   exit 0
else
   exit 1
fi
